//--- build.f
common/fq_pkg.sv
logic/sync_fifo.sv
logic/lane_compactor.sv
mc_fifo/mc_fifo.sv
mc_fifo/fetch_queue_top.sv
dv/tb_fetch_queue.sv

//--- common/fq_pkg.sv
// ==========================================================
// Fetch queue package
// Queue sizes, instruction slot type and lane count types
// ==========================================================
package fq_pkg;

  // One instruction slot
  typedef logic [31:0] slot_t;

  // Port counts
  localparam int FQ_WPORTS = 4;
  localparam int FQ_RPORTS = 2;
  localparam int FQ_BANKS  = (FQ_RPORTS > FQ_WPORTS) ? FQ_RPORTS : FQ_WPORTS;

  // Capacity, split evenly over the banks
  localparam int FQ_DEPTH      = 16;
  localparam int FQ_BANK_DEPTH = FQ_DEPTH / FQ_BANKS;

  // Rotating bank index
  typedef logic [$clog2(FQ_BANKS)-1:0] bank_idx_t;

  // Write lane count, 0 to FQ_WPORTS
  typedef logic [$clog2(FQ_WPORTS+1)-1:0] wcnt_t;

  // Read lane count, 0 to FQ_RPORTS
  typedef logic [$clog2(FQ_RPORTS+1)-1:0] rcnt_t;

endpackage : fq_pkg

//--- dv/tb_fetch_queue.sv
`timescale 1ns/100ps
// ==========================================================
// Fetch queue testbench
// Table of stimulus rows checked against a slot queue model
// ==========================================================
module tb_fetch_queue
  import fq_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_ROWS     = 128;
  // No bank is full up to this occupancy
  localparam int READY_LIMIT  = FQ_DEPTH - FQ_BANKS + (FQ_BANKS - FQ_WPORTS);

  logic                  clk;
  logic                  rst_n;
  logic                  flush_i;
  logic [FQ_WPORTS-1:0]  fetch_valid_i;
  slot_t [FQ_WPORTS-1:0] fetch_slot_i;
  logic                  fetch_ready_o;
  logic [FQ_RPORTS-1:0]  dec_ready_i;
  logic [FQ_RPORTS-1:0]  dec_valid_o;
  slot_t [FQ_RPORTS-1:0] dec_slot_o;

  // Stimulus table, one row per cycle
  int                    row_test  [MAX_ROWS];
  logic [FQ_WPORTS-1:0]  row_valid [MAX_ROWS];
  slot_t [FQ_WPORTS-1:0] row_slot  [MAX_ROWS];
  logic [FQ_RPORTS-1:0]  row_ready [MAX_ROWS];
  logic                  row_flush [MAX_ROWS];
  int                    n_rows;
  bit                    table_built;

  slot_t model_q [$];
  string test_name [1:6];
  int    test_errs;
  int    tests_passed;
  int    tests_failed;
  int    cur_test;

  fetch_queue_top fetch_queue_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_slot_i  (fetch_slot_i),
    .fetch_ready_o (fetch_ready_o),
    .dec_ready_i   (dec_ready_i),
    .dec_valid_o   (dec_valid_o),
    .dec_slot_o    (dec_slot_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ========================================================
  // Table construction
  // ========================================================
  // A held row repeats the previous fetch group unchanged
  task automatic add_row(input int t, input logic [3:0] valid, input logic [1:0] ready,
                         input logic flush, input bit hold);
    row_test[n_rows]  = t;
    row_ready[n_rows] = ready;
    row_flush[n_rows] = flush;
    if (hold && n_rows > 0) begin
      row_valid[n_rows] = row_valid[n_rows-1];
      row_slot[n_rows]  = row_slot[n_rows-1];
    end else begin
      row_valid[n_rows] = valid;
      for (int j = 0; j < FQ_WPORTS; j++) begin
        row_slot[n_rows][j] = $urandom;
      end
    end
    n_rows++;
  endtask

  task automatic add_rows(input int t, input logic [3:0] valid, input logic [1:0] ready,
                          input int count);
    repeat (count) add_row(t, valid, ready, 1'b0, 1'b0);
  endtask

  task automatic build_table();
    logic [1:0] ready;
    n_rows = 0;
    add_rows(1, 4'b0000, 2'b00, 2);
    add_rows(1, 4'b0000, 2'b11, 1);
    // Sparse masks, then drain
    add_rows(2, 4'b1010, 2'b00, 1);
    add_rows(2, 4'b0001, 2'b00, 1);
    add_rows(2, 4'b0110, 2'b00, 1);
    add_rows(2, 4'b1001, 2'b00, 1);
    add_rows(2, 4'b0100, 2'b00, 1);
    add_rows(2, 4'b0000, 2'b11, 5);
    // Fill past the ready limit and hold the refused group
    add_rows(3, 4'b1111, 2'b00, 4);
    add_row(3, 4'b0000, 2'b00, 1'b0, 1'b1);
    add_row(3, 4'b0000, 2'b00, 1'b0, 1'b1);
    add_row(3, 4'b0000, 2'b11, 1'b0, 1'b1);
    add_row(3, 4'b0000, 2'b11, 1'b0, 1'b1);
    add_row(3, 4'b0000, 2'b00, 1'b0, 1'b1);
    add_rows(3, 4'b0000, 2'b11, 8);
    // Random writes mixed with one and two lane reads
    for (int i = 0; i < 24; i++) begin
      case ($urandom_range(2))
        0:       ready = 2'b00;
        1:       ready = 2'b01;
        default: ready = 2'b11;
      endcase
      add_row(4, 4'($urandom), ready, 1'b0, 1'b0);
    end
    add_rows(4, 4'b0000, 2'b11, 8);
    // Back-pressure keeps the head still
    add_rows(5, 4'b1111, 2'b00, 2);
    add_rows(5, 4'b0000, 2'b00, 5);
    add_rows(5, 4'b0000, 2'b11, 4);
    // Flush with a write in the same cycle
    add_rows(6, 4'b1111, 2'b00, 2);
    add_row(6, 4'b0111, 2'b11, 1'b1, 1'b0);
    add_rows(6, 4'b0000, 2'b00, 1);
    add_rows(6, 4'b0011, 2'b00, 1);
    add_rows(6, 4'b1100, 2'b01, 1);
    add_rows(6, 4'b0000, 2'b11, 3);
  endtask

  // ========================================================
  // Model and checks
  // ========================================================
  task automatic check_outputs(input int r);
    logic                 exp_ready;
    logic [FQ_RPORTS-1:0] exp_valid;
    exp_ready = (model_q.size() <= READY_LIMIT);
    for (int i = 0; i < FQ_RPORTS; i++) begin
      exp_valid[i] = (model_q.size() > i);
    end
    assert (fetch_ready_o == exp_ready) else begin
      $display("Mismatch at %0t: row %0d fetch_ready_o %0b, expected %0b",
               $time, r, fetch_ready_o, exp_ready);
      test_errs++;
    end
    assert (dec_valid_o == exp_valid) else begin
      $display("Mismatch at %0t: row %0d dec_valid_o %b, expected %b",
               $time, r, dec_valid_o, exp_valid);
      test_errs++;
    end
    for (int i = 0; i < FQ_RPORTS; i++) begin
      if (exp_valid[i]) begin
        assert (dec_slot_o[i] == model_q[i]) else begin
          $display("Mismatch at %0t: row %0d dec_slot_o[%0d] %h, expected %h",
                   $time, r, i, dec_slot_o[i], model_q[i]);
          test_errs++;
        end
      end
    end
  endtask

  // Flush first, then pops, then accepted lanes in lane order
  task automatic model_step(input int r);
    int pops;
    bit taken;
    taken = (model_q.size() <= READY_LIMIT) && (row_valid[r] != '0);
    pops  = 0;
    if (row_flush[r]) begin
      model_q.delete();
    end else begin
      for (int i = 0; i < FQ_RPORTS; i++) begin
        if (row_ready[r][i] && model_q.size() > i) begin
          pops++;
        end
      end
      repeat (pops) void'(model_q.pop_front());
      if (taken) begin
        for (int j = 0; j < FQ_WPORTS; j++) begin
          if (row_valid[r][j]) begin
            model_q.push_back(row_slot[r][j]);
          end
        end
      end
    end
  endtask

  task automatic drive_row(input int r);
    fetch_valid_i <= row_valid[r];
    fetch_slot_i  <= row_slot[r];
    dec_ready_i   <= row_ready[r];
    flush_i       <= row_flush[r];
  endtask

  task automatic report_test(input int t);
    if (test_errs == 0) begin
      $display("Test %0d (%s): PASS", t, test_name[t]);
      tests_passed++;
    end else begin
      $display("Test %0d (%s): FAIL, %0d errors", t, test_name[t], test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  // ========================================================
  // Main sequence
  // ========================================================
  initial begin
    rst_n         <= 1'b0;
    flush_i       <= 1'b0;
    fetch_valid_i <= '0;
    fetch_slot_i  <= '0;
    dec_ready_i   <= '0;
    void'($urandom(47));
    test_name[1] = "reset state";
    test_name[2] = "sparse fetch masks";
    test_name[3] = "fill and hold";
    test_name[4] = "mixed reads and writes";
    test_name[5] = "back-pressure";
    test_name[6] = "flush";
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    cur_test = row_test[0];
    for (int r = 0; r < n_rows; r++) begin
      if (row_test[r] != cur_test) begin
        report_test(cur_test);
        cur_test = row_test[r];
      end
      drive_row(r);
      @(negedge clk);
      check_outputs(r);
      @(posedge clk);
      model_step(r);
    end
    @(negedge clk);
    check_outputs(n_rows);
    report_test(cur_test);
    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_built);
    #((n_rows + RESET_CYCLES + 50) * CLK_PERIOD);
    $display("Watchdog: run timed out after %0d table rows", n_rows);
    $display("Verification failed");
    $finish;
  end

endmodule : tb_fetch_queue

//--- logic/lane_compactor.sv
`timescale 1ns/100ps
// ==========================================================
// Lane compactor
// Packs a sparse fetch mask into lanes contiguous from lane 0
// ==========================================================
module lane_compactor
  import fq_pkg::*;
(
  input  logic [FQ_WPORTS-1:0]         lane_valid_i,
  input  slot_t [FQ_WPORTS-1:0]        lane_slot_i,
  output logic [FQ_WPORTS-1:0]         packed_valid_o,
  output slot_t [FQ_WPORTS-1:0]        packed_slot_o
);

  // Number of valid lanes below each input lane
  wcnt_t [FQ_WPORTS-1:0] prefix;
  wcnt_t                 total;

  always_comb begin
    total = '0;
    for (int j = 0; j < FQ_WPORTS; j++) begin
      prefix[j] = total;
      total     = total + wcnt_t'(lane_valid_i[j]);
    end
  end

  // ========================================================
  // Output lane selection
  // ========================================================
  // Output lane k takes the input lane whose prefix count is k,
  // so lane order is kept
  always_comb begin
    packed_slot_o = '0;
    for (int k = 0; k < FQ_WPORTS; k++) begin
      for (int j = 0; j < FQ_WPORTS; j++) begin
        if (lane_valid_i[j] && (prefix[j] == wcnt_t'(k))) begin
          packed_slot_o[k] = lane_slot_i[j];
        end
      end
    end
  end

  // Contiguous mask from the total count
  always_comb begin
    for (int k = 0; k < FQ_WPORTS; k++) begin
      packed_valid_o[k] = (total > wcnt_t'(k));
    end
  end

endmodule : lane_compactor

//--- logic/sync_fifo.sv
`timescale 1ns/100ps
// ==========================================================
// Single-bank synchronous FIFO with flush
// Head slot is shown combinationally on data_o
// ==========================================================
module sync_fifo
  import fq_pkg::*;
#(
  // Power of two, at least 2
  parameter int DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  flush_i,
  input  logic  push_i,
  input  logic  pop_i,
  input  slot_t data_i,
  output slot_t data_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int AW = $clog2(DEPTH);

  slot_t       mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        push_en;
  logic        pop_en;

  // Extra wrap bit tells full from empty
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty_o = (wr_ptr == rd_ptr);

  assign push_en = push_i && !full_o && !flush_i;
  assign pop_en  = pop_i && !empty_o && !flush_i;

  // ========================================================
  // Pointers
  // ========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ========================================================
  // Storage
  // ========================================================
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem[wr_ptr[AW-1:0]] <= data_i;
    end
  end

  // Head of queue, readable one cycle after the push
  assign data_o = mem[rd_ptr[AW-1:0]];

  // Bank control in the parent must never overrun or underrun a bank
  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && !flush_i) |-> !full_o)
    else $error("sync_fifo: push while full");

  a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
    (pop_i && !flush_i) |-> !empty_o)
    else $error("sync_fifo: pop while empty");

endmodule : sync_fifo

//--- mc_fifo/fetch_queue_top.sv
`timescale 1ns/100ps
// ==========================================================
// Instruction fetch queue
// Lane compactor in front of the banked multi-port FIFO
// ==========================================================
module fetch_queue_top
  import fq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  // Fetch side, mask may be sparse
  input  logic [FQ_WPORTS-1:0]  fetch_valid_i,
  input  slot_t [FQ_WPORTS-1:0] fetch_slot_i,
  output logic                  fetch_ready_o,
  // Decode side, oldest slot on lane 0
  input  logic [FQ_RPORTS-1:0]  dec_ready_i,
  output logic [FQ_RPORTS-1:0]  dec_valid_o,
  output slot_t [FQ_RPORTS-1:0] dec_slot_o
);

  logic [FQ_WPORTS-1:0]  packed_valid;
  slot_t [FQ_WPORTS-1:0] packed_slot;

  lane_compactor lane_compactor_inst (
    .lane_valid_i   (fetch_valid_i),
    .lane_slot_i    (fetch_slot_i),
    .packed_valid_o (packed_valid),
    .packed_slot_o  (packed_slot)
  );

  // Group taken whole when ready and any lane valid
  mc_fifo mc_fifo_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .write_valid_i (packed_valid),
    .write_data_i  (packed_slot),
    .write_ready_o (fetch_ready_o),
    .read_valid_o  (dec_valid_o),
    .read_ready_i  (dec_ready_i),
    .read_data_o   (dec_slot_o)
  );

endmodule : fetch_queue_top

//--- mc_fifo/mc_fifo.sv
`timescale 1ns/100ps
// ==========================================================
// Banked multi-port FIFO
// Four bank FIFOs behind rotating write and read indices
// ==========================================================
module mc_fifo
  import fq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  logic [FQ_WPORTS-1:0]  write_valid_i,
  input  slot_t [FQ_WPORTS-1:0] write_data_i,
  output logic                  write_ready_o,
  output logic [FQ_RPORTS-1:0]  read_valid_o,
  input  logic [FQ_RPORTS-1:0]  read_ready_i,
  output slot_t [FQ_RPORTS-1:0] read_data_o
);

  wcnt_t                          write_num;
  rcnt_t                          read_num;
  logic [$clog2(FQ_BANKS+1)-1:0]  count_full;
  logic                           write_fire;
  logic                           read_fire;

  bank_idx_t [FQ_BANKS-1:0]       bank_wr_idx;
  bank_idx_t [FQ_BANKS-1:0]       bank_rd_idx;
  bank_idx_t [FQ_RPORTS-1:0]      port_bank;

  logic [FQ_BANKS-1:0]            bank_full;
  logic [FQ_BANKS-1:0]            bank_empty;
  logic [FQ_BANKS-1:0]            bank_push;
  logic [FQ_BANKS-1:0]            bank_pop;
  slot_t [FQ_BANKS-1:0]           bank_din;
  slot_t [FQ_BANKS-1:0]           bank_dout;

  // ========================================================
  // Lane counts and write ready
  // ========================================================
  always_comb begin
    count_full = '0;
    for (int b = 0; b < FQ_BANKS; b++) begin
      count_full = count_full + ($clog2(FQ_BANKS+1))'(bank_full[b]);
    end
    write_num = '0;
    for (int i = 0; i < FQ_WPORTS; i++) begin
      write_num = write_num + wcnt_t'(write_valid_i[i]);
    end
    read_num = '0;
    for (int i = 0; i < FQ_RPORTS; i++) begin
      read_num = read_num + rcnt_t'(read_ready_i[i] & read_valid_o[i]);
    end
  end

  // Registered bank state only, so fetch_ready has no input path
  assign write_ready_o = (count_full <= (FQ_BANKS - FQ_WPORTS));

  assign write_fire = (|write_valid_i) && write_ready_o && !flush_i;
  assign read_fire  = (read_num != '0) && !flush_i;

  // ========================================================
  // Per-bank control
  // ========================================================
  for (genvar b = 0; b < FQ_BANKS; b++) begin : gen_bank
    // Index counts down, so a bank takes lane idx when idx < count
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        bank_wr_idx[b] <= bank_idx_t'(b);
        bank_rd_idx[b] <= bank_idx_t'(b);
      end else if (flush_i) begin
        bank_wr_idx[b] <= bank_idx_t'(b);
        bank_rd_idx[b] <= bank_idx_t'(b);
      end else begin
        if (write_fire) begin
          bank_wr_idx[b] <= bank_wr_idx[b] - bank_idx_t'(write_num);
        end
        if (read_fire) begin
          bank_rd_idx[b] <= bank_rd_idx[b] - bank_idx_t'(read_num);
        end
      end
    end

    assign bank_push[b] = write_fire && (wcnt_t'(bank_wr_idx[b]) < write_num);
    assign bank_pop[b]  = read_fire && (rcnt_t'(bank_rd_idx[b]) < read_num);
    assign bank_din[b]  = write_data_i[bank_wr_idx[b]];

    sync_fifo #(
      .DEPTH (FQ_BANK_DEPTH)
    ) sync_fifo_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush_i (flush_i),
      .push_i  (bank_push[b]),
      .pop_i   (bank_pop[b]),
      .data_i  (bank_din[b]),
      .data_o  (bank_dout[b]),
      .full_o  (bank_full[b]),
      .empty_o (bank_empty[b])
    );
  end

  // ========================================================
  // Read ports
  // ========================================================
  for (genvar p = 0; p < FQ_RPORTS; p++) begin : gen_rport
    // Bank holding the p-th oldest slot
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        port_bank[p] <= bank_idx_t'(p);
      end else if (flush_i) begin
        port_bank[p] <= bank_idx_t'(p);
      end else if (read_fire) begin
        port_bank[p] <= port_bank[p] + bank_idx_t'(read_num);
      end
    end

    assign read_valid_o[p] = !bank_empty[port_bank[p]];
    assign read_data_o[p]  = bank_dout[port_bank[p]];
  end

  // Lanes from the compactor and from decode start at lane 0
  a_wr_contig : assert property (@(posedge clk) disable iff (!rst_n)
    (write_valid_i & (write_valid_i + 1'b1)) == '0)
    else $error("mc_fifo: write_valid_i not contiguous");

  a_rd_contig : assert property (@(posedge clk) disable iff (!rst_n)
    (read_ready_i & (read_ready_i + 1'b1)) == '0)
    else $error("mc_fifo: read_ready_i not contiguous");

endmodule : mc_fifo

//--- run.sh
#!/bin/sh
# Compile and run the fetch queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f \
  --top-module tb_fetch_queue -Mdir obj_dir -o sim_fetch_queue
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_fetch_queue)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
